/* flist.f */
design/video_pkg.sv
design/board_io_pkg.sv
design/button_debounce.sv
design/video_byte_serializer.sv
design/hsmc_display_top.sv
tests/tb_hsmc_display.sv

/* Makefile */
TOP := tb_hsmc_display

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall design/video_pkg.sv design/board_io_pkg.sv \
		design/button_debounce.sv design/video_byte_serializer.sv \
		design/hsmc_display_top.sv --top-module hsmc_display_top

clean:
	rm -rf obj_dir

/* tests/display_cases.txt */
# kind, then hex fields, one case per line
# reset  lcd_data vga_data {lcd_den,lcd_hd,lcd_vd,vga_blank,vga_hs,vga_vs} buttons_clean
# pixel  lcd r g b ctrl  vga r g b ctrl  lcd {den,hd,vd}  vga {blank,hs,vs}
# dclk   ss_n en sclk scl  adc_dclk adc_cs_n scen
# bounce pattern cycles buttons_clean
# settle pattern edges buttons_clean_after
# ctrl is {blank,hs,vs}

reset 00 000 18 3

pixel 12 34 56 7 a1 b2 c3 5 4 5
pixel ff 00 80 0 01 02 03 2 3 2
pixel 00 ff 7f 4 fe dc ba 7 7 7
pixel 5a a5 3c 2 c0 de 42 0 1 0
pixel 80 40 20 5 11 22 33 6 6 6
pixel 01 23 45 3 67 89 ab 1 0 1
pixel aa 55 aa 6 00 00 00 4 5 4
pixel 0f f0 99 1 ff ff ff 3 2 3

# select low hands the pin to the SPI clock
dclk 0 0 1 0 1 0 0
dclk 0 1 0 1 0 0 1
dclk 0 0 0 1 0 0 0
dclk 0 1 1 1 1 0 1
# config enable low hands it to scl
dclk 1 0 0 1 1 1 0
dclk 1 0 1 0 0 1 0
dclk 1 1 1 1 0 1 1
dclk 1 1 0 0 0 1 1

bounce 2 3 3
bounce 1 7 3
settle 2 8 2
bounce 3 7 2
settle 0 8 0
bounce 1 5 0
settle 3 8 3
bounce 0 7 3

/* tests/tb_hsmc_display.sv */
`timescale 1ns/1ps

module tb_hsmc_display
  import video_pkg::*;
  import board_io_pkg::*;
();

  localparam int    DEBOUNCE   = 8;
  localparam int    MAX_CASES  = 64;
  localparam int    MAX_FIELDS = 10;
  localparam string CASES_FILE = "tests/display_cases.txt";

  logic        clk_120 = 1'b0;
  logic        arst_n;
  button_vec_t buttons;
  button_vec_t buttons_clean;
  pixel_t      lcd_pixel;
  pixel_t      vga_pixel;
  touch_spi_t  touch_spi;
  lcd_cfg_t    lcd_cfg;
  color_byte_t lcd_data;
  logic        lcd_den;
  logic        lcd_hd;
  logic        lcd_vd;
  vga_dac_t    vga_data;
  logic        vga_blank;
  logic        vga_hs;
  logic        vga_vs;
  logic        adc_cs_n;
  logic        adc_dclk;
  logic        scen;

  string       case_kind [MAX_CASES];
  logic [31:0] case_field [MAX_CASES][MAX_FIELDS];
  int          case_total;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rand_state;
  int          phase;                              // serializer phase after the last edge
  button_vec_t button_level;                       // level the buttons rest at
  button_vec_t clean_expect;

  hsmc_display_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE)
  ) UUT (
    .clk_120       (clk_120),
    .arst_n        (arst_n),
    .buttons       (buttons),
    .buttons_clean (buttons_clean),
    .lcd_pixel     (lcd_pixel),
    .vga_pixel     (vga_pixel),
    .touch_spi     (touch_spi),
    .lcd_cfg       (lcd_cfg),
    .lcd_data      (lcd_data),
    .lcd_den       (lcd_den),
    .lcd_hd        (lcd_hd),
    .lcd_vd        (lcd_vd),
    .vga_data      (vga_data),
    .vga_blank     (vga_blank),
    .vga_hs        (vga_hs),
    .vga_vs        (vga_vs),
    .adc_cs_n      (adc_cs_n),
    .adc_dclk      (adc_dclk),
    .scen          (scen)
  );

  always #20 clk_120 = ~clk_120;                   // 40 ns period

  always @(posedge clk_120) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  function automatic logic [31:0] next_random(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int fields_for(string kind);
    int count;
    count = -1;                                    // unknown kind
    if (kind == "reset") begin
      count = 4;
    end else if (kind == "pixel") begin
      count = 10;
    end else if (kind == "dclk") begin
      count = 7;
    end else if (kind == "bounce" || kind == "settle") begin
      count = 3;
    end
    return count;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else
      abort_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual));
  endtask

  task automatic load_cases();
    int          fd;
    int          code;
    int          ch;
    int          count;
    string       kind;
    logic [31:0] value;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      abort_run("the cases file could not be opened");
    end
    case_total = 0;
    code = $fscanf(fd, "%s", kind);
    while (code == 1) begin
      if (kind.getc(0) == "#") begin
        ch = $fgetc(fd);                           // drop the rest of the comment
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        count = fields_for(kind);
        if (count < 0 || case_total == MAX_CASES) begin
          abort_run({"the cases file holds a bad or extra line of kind ", kind});
        end
        for (int j = 0; j < count; j++) begin
          code = $fscanf(fd, "%h", value);
          if (code != 1) begin
            abort_run({"a line of kind ", kind, " has too few fields"});
          end
          case_field[case_total][j] = value;
        end
        case_kind[case_total] = kind;
        case_total++;
      end
      code = $fscanf(fd, "%s", kind);
    end
    $fclose(fd);
    cycle_limit = 20 * case_total + 100;
  endtask

  task automatic advance_edge();
    @(posedge clk_120);
    phase = (phase == BYTES_PER_PIXEL - 1) ? 0 : phase + 1;
    if (phase == 0) begin                          // new pixel slot, fill it
      rand_state = next_random(rand_state);
      lcd_pixel <= pixel_t'(rand_state[31:5]);
      rand_state = next_random(rand_state);
      vga_pixel <= pixel_t'(rand_state[31:5]);
    end
  endtask

  task automatic wait_settled();
    @(negedge clk_120);
  endtask

  task automatic check_reset_state(int idx);
    wait_settled();
    expect_value("lcd_data", case_field[idx][0], 32'(lcd_data));
    expect_value("vga_data", case_field[idx][1], 32'(vga_data));
    expect_value("{lcd_den,lcd_hd,lcd_vd,vga_blank,vga_hs,vga_vs}", case_field[idx][2],
                 32'({lcd_den, lcd_hd, lcd_vd, vga_blank, vga_hs, vga_vs}));
    expect_value("buttons_clean", case_field[idx][3], 32'(buttons_clean));
    clean_expect = case_field[idx][3][BUTTON_COUNT-1:0];
  endtask

  task automatic serialize_pixel(int idx);
    pixel_t      lcd_in;
    pixel_t      vga_in;
    color_byte_t lcd_bytes [BYTES_PER_PIXEL];
    color_byte_t vga_bytes [BYTES_PER_PIXEL];
    for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
      lcd_bytes[k] = case_field[idx][k][7:0];      // red, green, blue in that order
      vga_bytes[k] = case_field[idx][k + 4][7:0];
    end
    lcd_in.red   = lcd_bytes[0];
    lcd_in.green = lcd_bytes[1];
    lcd_in.blue  = lcd_bytes[2];
    lcd_in.ctrl  = case_field[idx][3][2:0];
    vga_in.red   = vga_bytes[0];
    vga_in.green = vga_bytes[1];
    vga_in.blue  = vga_bytes[2];
    vga_in.ctrl  = case_field[idx][7][2:0];
    do begin
      advance_edge();
    end while (phase != 0);
    lcd_pixel <= lcd_in;                           // replaces the filler of this slot
    vga_pixel <= vga_in;
    for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
      advance_edge();
      wait_settled();
      expect_value("lcd_data", 32'(lcd_bytes[k]), 32'(lcd_data));
      expect_value("vga_data", 32'({vga_bytes[k], 2'b00}), 32'(vga_data));
      expect_value("{lcd_den,lcd_hd,lcd_vd}", case_field[idx][8],
                   32'({lcd_den, lcd_hd, lcd_vd}));
      expect_value("{vga_blank,vga_hs,vga_vs}", case_field[idx][9],
                   32'({vga_blank, vga_hs, vga_vs}));
    end
  endtask

  task automatic select_clock_pin(int idx);
    advance_edge();
    touch_spi <= '{sclk: case_field[idx][2][0], ss_n: case_field[idx][0][0]};
    lcd_cfg   <= '{en: case_field[idx][1][0], scl: case_field[idx][3][0]};
    wait_settled();
    expect_value("adc_dclk", case_field[idx][4], 32'(adc_dclk));
    expect_value("adc_cs_n", case_field[idx][5], 32'(adc_cs_n));
    expect_value("scen", case_field[idx][6], 32'(scen));
  endtask

  task automatic reject_glitch(int idx);
    int width;
    width = int'(case_field[idx][1]);
    advance_edge();
    buttons <= case_field[idx][0][BUTTON_COUNT-1:0];
    for (int i = 1; i <= width; i++) begin
      advance_edge();
      if (i == width) begin
        buttons <= button_level;                   // bounces back before the count ends
      end
      wait_settled();
      expect_value("buttons_clean", case_field[idx][2], 32'(buttons_clean));
    end
    repeat (10) begin
      advance_edge();
      wait_settled();
      expect_value("buttons_clean", case_field[idx][2], 32'(buttons_clean));
    end
  endtask

  task automatic accept_level(int idx);
    int edges;
    edges = int'(case_field[idx][1]);
    advance_edge();
    button_level = case_field[idx][0][BUTTON_COUNT-1:0];
    buttons <= button_level;
    for (int i = 1; i <= edges; i++) begin
      advance_edge();
      wait_settled();
      if (i < edges) begin
        expect_value("buttons_clean", 32'(clean_expect), 32'(buttons_clean));
      end else begin
        expect_value("buttons_clean", case_field[idx][2], 32'(buttons_clean));
      end
    end
    clean_expect = case_field[idx][2][BUTTON_COUNT-1:0];
  endtask

  initial begin
    arst_n       = 1'b0;
    buttons      = BUTTONS_RELEASED;
    lcd_pixel    = '0;
    vga_pixel    = '0;
    touch_spi    = '{sclk: 1'b0, ss_n: 1'b1};
    lcd_cfg      = '{en: 1'b1, scl: 1'b0};
    cycle_count  = 0;
    cycle_limit  = 100;
    phase        = 0;
    rand_state   = 32'hac7;
    button_level = BUTTONS_RELEASED;
    clean_expect = BUTTONS_RELEASED;
    load_cases();
    repeat (4) @(posedge clk_120);
    arst_n <= 1'b1;                                // first working edge is the next one
    for (int i = 0; i < case_total; i++) begin
      if (case_kind[i] == "reset") begin
        check_reset_state(i);
      end else if (case_kind[i] == "pixel") begin
        serialize_pixel(i);
      end else if (case_kind[i] == "dclk") begin
        select_clock_pin(i);
      end else if (case_kind[i] == "bounce") begin
        reject_glitch(i);
      end else begin
        accept_level(i);
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

/* design/hsmc_display_top.sv */
`timescale 1ns/1ps

module hsmc_display_top
  import video_pkg::*;
  import board_io_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = 50000            // 1 ms at 50 MHz
) (
  input  logic        clk_120,
  input  logic        arst_n,

  // push buttons
  input  button_vec_t buttons,
  output button_vec_t buttons_clean,

  // video streams, one pixel every three clocks
  input  pixel_t      lcd_pixel,
  input  pixel_t      vga_pixel,

  // strobes that share the touch controller clock pin
  input  touch_spi_t  touch_spi,
  input  lcd_cfg_t    lcd_cfg,

  // parallel LCD
  output color_byte_t lcd_data,
  output logic        lcd_den,
  output logic        lcd_hd,
  output logic        lcd_vd,

  // VGA DAC
  output vga_dac_t    vga_data,
  output logic        vga_blank,
  output logic        vga_hs,
  output logic        vga_vs,

  // touch ADC and LCD config
  output logic        adc_cs_n,
  output logic        adc_dclk,
  output logic        scen
);

  localparam int COUNT_WIDTH = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  video_ctrl_t lcd_ctrl;
  video_ctrl_t vga_ctrl;
  color_byte_t vga_byte;

  button_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .COUNT_WIDTH     (COUNT_WIDTH)
  ) u_debounce (
    .clk_120 (clk_120),
    .arst_n  (arst_n),
    .raw     (buttons),
    .clean   (buttons_clean)
  );

  video_byte_serializer u_lcd_serial (
    .clk_120  (clk_120),
    .arst_n   (arst_n),
    .pixel    (lcd_pixel),
    .byte_out (lcd_data),
    .ctrl_out (lcd_ctrl)
  );

  video_byte_serializer u_vga_serial (
    .clk_120  (clk_120),
    .arst_n   (arst_n),
    .pixel    (vga_pixel),
    .byte_out (vga_byte),
    .ctrl_out (vga_ctrl)
  );

  // panel wants low-going syncs
  assign lcd_hd  = ~lcd_ctrl.hs;
  assign lcd_vd  = ~lcd_ctrl.vs;
  assign lcd_den = lcd_ctrl.blank;

  assign vga_data  = '{level: vga_byte, frac: 2'b00};   // byte into bits 9:2
  assign vga_blank = vga_ctrl.blank;
  assign vga_hs    = vga_ctrl.hs;
  assign vga_vs    = vga_ctrl.vs;

  // SPI select wins the clock pin, config port gets it otherwise
  always_comb begin
    if (!touch_spi.ss_n) begin
      adc_dclk = touch_spi.sclk;
    end else if (!lcd_cfg.en) begin
      adc_dclk = lcd_cfg.scl;
    end else begin
      adc_dclk = DCLK_IDLE;
    end
  end

  assign adc_cs_n = touch_spi.ss_n;
  assign scen     = lcd_cfg.en;

endmodule

/* design/video_byte_serializer.sv */
`timescale 1ns/1ps

module video_byte_serializer
  import video_pkg::*;
(
  input  logic        clk_120,
  input  logic        arst_n,
  input  pixel_t      pixel,                       // held three cycles from phase 0
  output color_byte_t byte_out,
  output video_ctrl_t ctrl_out
);

  // red leaves straight from the input, so only the rest is held
  typedef struct packed {
    color_byte_t green;
    color_byte_t blue;
  } held_t;

  phase_t      phase;
  phase_t      phase_next;
  held_t       hold;
  color_byte_t byte_next;
  color_byte_t byte_q;
  video_ctrl_t ctrl_q;
  logic        first;                              // pixel boundary

  assign first      = (phase == PHASE_RED);
  assign phase_next = (phase == PHASE_BLUE) ? PHASE_RED : phase + 1'b1;

  // free running 0, 1, 2 phase count
  always_ff @(posedge clk_120 or negedge arst_n) begin
    if (!arst_n) begin
      phase <= PHASE_RED;
    end else begin
      phase <= phase_next;
    end
  end

  always_ff @(posedge clk_120) begin
    if (first) begin
      hold.green <= pixel.green;
      hold.blue  <= pixel.blue;
    end
  end

  always_comb begin
    unique case (phase)
      PHASE_RED:   byte_next = pixel.red;
      PHASE_GREEN: byte_next = hold.green;
      PHASE_BLUE:  byte_next = hold.blue;
      default:     byte_next = '0;                 // unreachable phase
    endcase
  end

  always_ff @(posedge clk_120 or negedge arst_n) begin
    if (!arst_n) begin
      byte_q <= '0;
      ctrl_q <= '0;
    end else begin
      byte_q <= byte_next;
      if (first) begin
        ctrl_q <= pixel.ctrl;                      // lines up with the red byte
      end
    end
  end

  assign byte_out = byte_q;
  assign ctrl_out = ctrl_q;

endmodule

/* design/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce
  import board_io_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = 50000,           // stable cycles before output follows
  parameter int COUNT_WIDTH     = 16               // holds DEBOUNCE_CYCLES - 1
) (
  input  logic        clk_120,
  input  logic        arst_n,
  input  button_vec_t raw,                         // straight from the pins
  output button_vec_t clean
);

  localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(DEBOUNCE_CYCLES - 1);

  button_vec_t clean_q;

  assign clean = clean_q;

  // one independent filter per button
  for (genvar b = 0; b < BUTTON_COUNT; b++) begin : g_bit
    logic [COUNT_WIDTH-1:0] count;
    logic                   differs;

    assign differs = raw[b] ^ clean_q[b];          // input wants a new level

    always_ff @(posedge clk_120 or negedge arst_n) begin
      if (!arst_n) begin
        count      <= '0;
        clean_q[b] <= BUTTONS_RELEASED[b];         // released after reset
      end else if (!differs) begin
        count <= '0;                               // stable or bounced back
      end else if (count == COUNT_LAST) begin
        count      <= '0;
        clean_q[b] <= raw[b];                      // held long enough, accept it
      end else begin
        count <= count + 1'b1;
      end
    end
  end : g_bit

endmodule

/* design/board_io_pkg.sv */
package board_io_pkg;

  localparam int BUTTON_COUNT = 2;

  typedef logic [BUTTON_COUNT-1:0] button_vec_t;   // active low

  localparam button_vec_t BUTTONS_RELEASED = '1;   // idle level of the buttons

  // touch-panel SPI master pins that reach the connector
  typedef struct packed {
    logic sclk;
    logic ss_n;                                    // active low select
  } touch_spi_t;

  // LCD configuration port strobes
  typedef struct packed {
    logic en;                                      // low while config owns the clock pin
    logic scl;
  } lcd_cfg_t;

  localparam logic DCLK_IDLE = 1'b0;               // shared clock pin when nobody drives it

endpackage

/* design/video_pkg.sv */
package video_pkg;

  typedef logic [7:0] color_byte_t;            // one colour component

  typedef struct packed {
    logic blank;                               // as supplied by the source
    logic hs;
    logic vs;
  } video_ctrl_t;

  typedef struct packed {
    color_byte_t red;
    color_byte_t green;
    color_byte_t blue;
    video_ctrl_t ctrl;
  } pixel_t;

  localparam int BYTES_PER_PIXEL = 3;          // 3:1 pixel to byte rate
  localparam int PHASE_WIDTH = $clog2(BYTES_PER_PIXEL);

  typedef logic [PHASE_WIDTH-1:0] phase_t;

  localparam phase_t PHASE_RED   = phase_t'(0);
  localparam phase_t PHASE_GREEN = phase_t'(1);
  localparam phase_t PHASE_BLUE  = phase_t'(BYTES_PER_PIXEL - 1);

  // DAC takes the byte left aligned, low bits tied off
  typedef struct packed {
    color_byte_t level;
    logic [1:0]  frac;
  } vga_dac_t;

endpackage
